// File: hw/usb_ep_pkg.sv
`default_nettype none

package usb_ep_pkg;

  // Transfer phase of the Bulk-In endpoint
  typedef enum logic [1:0] {
    IDLE,
    SEND,
    RESP,
    HALT
  } ep_state_e;

  // Decoded read command, len holds the byte count minus one
  typedef struct packed {
    logic        apb;
    logic [3:0]  tag;
    logic [15:0] len;
  } ep_cmd_t;

  // One byte-stream beat
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } axis_byte_t;

  // Packet controls into the FIFO
  typedef struct packed {
    logic save;
    logic next;
    logic redo;
  } pkt_strobe_t;

  // High-speed bulk packet limit
  localparam int MAX_PACKET_LENGTH = 512;
  localparam int SIZE_BITS = 10;

  // Packet FIFO geometry, pointers carry one wrap bit
  localparam int FIFO_DEPTH = 2048;
  localparam int ADDR_BITS = $clog2(FIFO_DEPTH);
  localparam int PTR_BITS = ADDR_BITS + 1;

  // Idle SEND cycles before the endpoint stalls
  localparam int TIMEOUT_TICKS = 64;
  localparam int TICK_BITS = $clog2(TIMEOUT_TICKS);

  // Status block contents
  localparam logic [31:0] MAGIC = "TART";
  localparam logic [3:0] STATUS_SUCCESS = 4'h0;
  localparam int STATUS_BYTES = 7;

endpackage

`default_nettype wire

// File: hw/bulk_in_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module bulk_in_ctrl (
  input  wire logic                                 clock,
  input  wire logic                                 rst_n_i,
  // Control pipe
  input  wire logic                                 set_conf_i,
  input  wire logic                                 clr_conf_i,
  input  wire logic [usb_ep_pkg::SIZE_BITS-1:0]     max_size_i,
  // USB controller
  input  wire logic                                 selected_i,
  input  wire logic                                 ack_recv_i,
  input  wire logic                                 ack_sent_i,
  input  wire logic                                 timedout_i,
  // Transfer events
  input  wire logic                                 cmd_vld_i,
  input  wire logic                                 data_beat_i,
  input  wire logic                                 data_done_i,
  input  wire logic                                 resp_done_i,
  input  wire logic [usb_ep_pkg::PTR_BITS-1:0]      fifo_space_i,
  output usb_ep_pkg::ep_state_e                     state_o,
  output usb_ep_pkg::pkt_strobe_t                   strobe_o,
  output logic                                      clear_o,
  output logic                                      ep_ready_o,
  output logic                                      stalled_o,
  output logic                                      parity_o
);

  usb_ep_pkg::ep_state_e            state_q;
  usb_ep_pkg::pkt_strobe_t          strobe_q;
  logic                             clear_q;
  logic                             enabled_q;
  logic                             ready_q;
  logic                             parity_q;
  logic [usb_ep_pkg::TICK_BITS-1:0] ticks_q;
  logic [usb_ep_pkg::SIZE_BITS-1:0] pkt_cnt_q;
  logic                             timeout;
  logic                             pkt_full;
  logic                             save;

  // Last allowed idle cycle of the data phase
  assign timeout = state_q == usb_ep_pkg::SEND && !data_beat_i &&
                   ticks_q == usb_ep_pkg::TICK_BITS'(usb_ep_pkg::TIMEOUT_TICKS - 1);

  // Open packet hits max_size_i on this beat
  assign pkt_full = data_beat_i && (pkt_cnt_q + 1'b1) == max_size_i;

  // Close on data last, size limit, or the final status byte
  assign save = data_done_i || pkt_full || resp_done_i;

  // Set or clear of the configuration resets the endpoint a cycle later
  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      clear_q <= 1'b0;
    end else begin
      clear_q <= set_conf_i || clr_conf_i;
    end
  end

  // Enable survives the clear pulse it triggers
  always_ff @(posedge clock) begin
    if (!rst_n_i || clr_conf_i) begin
      enabled_q <= 1'b0;
    end else if (set_conf_i) begin
      enabled_q <= 1'b1;
    end
  end

  // Transfer phases, HALT only leaves through a clear
  always_ff @(posedge clock) begin
    if (!rst_n_i || clear_q) begin
      state_q <= usb_ep_pkg::IDLE;
    end else begin
      case (state_q)
        usb_ep_pkg::IDLE: begin
          state_q <= (cmd_vld_i && enabled_q) ? usb_ep_pkg::SEND : state_q;
        end
        usb_ep_pkg::SEND: begin
          state_q <= data_done_i ? usb_ep_pkg::RESP :
                     timeout     ? usb_ep_pkg::HALT : state_q;
        end
        usb_ep_pkg::RESP: begin
          state_q <= resp_done_i ? usb_ep_pkg::IDLE : state_q;
        end
        default: begin
          state_q <= state_q;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n_i || clear_q) begin
      ticks_q   <= '0;
      pkt_cnt_q <= '0;
      strobe_q  <= '0;
      parity_q  <= 1'b0;
      ready_q   <= 1'b0;
    end else begin
      // Stall timer restarts on every accepted byte
      if (state_q != usb_ep_pkg::SEND || data_beat_i) begin
        ticks_q <= '0;
      end else begin
        ticks_q <= ticks_q + 1'b1;
      end
      // Byte count of the open packet
      if (save) begin
        pkt_cnt_q <= '0;
      end else if (data_beat_i) begin
        pkt_cnt_q <= pkt_cnt_q + 1'b1;
      end
      strobe_q.save <= save;
      // Host acknowledge frees, host timeout replays
      strobe_q.next <= selected_i && ack_recv_i;
      strobe_q.redo <= selected_i && timedout_i;
      // DATA0/DATA1 toggle
      if (selected_i && ack_sent_i) begin
        parity_q <= ~parity_q;
      end
      // Room for a full packet needed before the host is told to poll
      ready_q <= enabled_q && state_q != usb_ep_pkg::HALT &&
                 fifo_space_i >= usb_ep_pkg::PTR_BITS'(usb_ep_pkg::MAX_PACKET_LENGTH);
    end
  end

  assign state_o    = state_q;
  assign strobe_o   = strobe_q;
  assign clear_o    = clear_q;
  assign ep_ready_o = ready_q;
  assign stalled_o  = state_q == usb_ep_pkg::HALT;
  assign parity_o   = parity_q;

  // Host never acknowledges and times out the same packet
  a_strobe_excl: assert property (@(posedge clock) disable iff (!rst_n_i)
    !(strobe_q.next && strobe_q.redo));

  // Command source waits for the previous transfer to finish
  a_cmd_idle: assert property (@(posedge clock) disable iff (!rst_n_i || clear_q)
    cmd_vld_i |-> state_q == usb_ep_pkg::IDLE);

endmodule

`default_nettype wire

// File: hw/packet_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module packet_fifo (
  input  wire logic                                 clock,
  input  wire logic                                 rst_n_i,
  input  wire logic                                 clear_i,
  input  wire usb_ep_pkg::pkt_strobe_t              strobe_i,
  // Write side
  input  wire usb_ep_pkg::axis_byte_t               s_i,
  input  wire logic                                 s_valid_i,
  output logic                                      s_ready_o,
  // Read side, towards the USB controller
  output usb_ep_pkg::axis_byte_t                    m_o,
  output logic                                      m_valid_o,
  input  wire logic                                 m_ready_i,
  output logic [usb_ep_pkg::PTR_BITS-1:0]           space_o
);

  usb_ep_pkg::axis_byte_t mem [usb_ep_pkg::FIFO_DEPTH];

  // Write, saved, read and replay base pointers
  logic [usb_ep_pkg::PTR_BITS-1:0] wr_ptr;
  logic [usb_ep_pkg::PTR_BITS-1:0] sv_ptr;
  logic [usb_ep_pkg::PTR_BITS-1:0] rd_ptr;
  logic [usb_ep_pkg::PTR_BITS-1:0] base_ptr;
  logic [usb_ep_pkg::PTR_BITS-1:0] used;
  logic [usb_ep_pkg::PTR_BITS-1:0] stage_ptr;
  usb_ep_pkg::axis_byte_t          stage_q;
  usb_ep_pkg::axis_byte_t          out_q;
  logic                            stage_vld;
  logic                            out_vld;
  logic                            wait_q;
  logic                            full;
  logic                            accept;
  logic                            load;

  // Bytes held from the replay base up to the write pointer
  assign used      = wr_ptr - base_ptr;
  assign full      = used[usb_ep_pkg::ADDR_BITS];
  assign space_o   = usb_ep_pkg::PTR_BITS'(usb_ep_pkg::FIFO_DEPTH) - used;
  assign s_ready_o = !full;
  assign accept    = s_valid_i && !full;

  // Staged byte sits one slot behind the write pointer
  assign stage_ptr = wr_ptr - 1'b1;

  // Fetch only saved bytes, and stop once a packet's last byte is out
  assign load = rd_ptr != sv_ptr && !wait_q && !(out_vld && out_q.last) &&
                (!out_vld || m_ready_i);

  // Datapath, a save strobe marks the staged byte as packet end
  always_ff @(posedge clock) begin
    if (stage_vld) begin
      mem[stage_ptr[usb_ep_pkg::ADDR_BITS-1:0]] <= {stage_q.data,
                                                     stage_q.last | strobe_i.save};
    end
    if (accept) begin
      stage_q <= s_i;
    end
    if (load) begin
      out_q <= mem[rd_ptr[usb_ep_pkg::ADDR_BITS-1:0]];
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n_i || clear_i) begin
      wr_ptr    <= '0;
      sv_ptr    <= '0;
      rd_ptr    <= '0;
      base_ptr  <= '0;
      stage_vld <= 1'b0;
      out_vld   <= 1'b0;
      wait_q    <= 1'b0;
    end else begin
      stage_vld <= accept;
      if (accept) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      // Saved pointer covers the byte being staged this cycle
      if (strobe_i.save) begin
        sv_ptr <= wr_ptr;
      end
      // Acknowledged packet gives its space back
      if (strobe_i.next) begin
        base_ptr <= rd_ptr;
      end
      // Replay rewinds to the start of the sent packet
      if (strobe_i.redo) begin
        rd_ptr <= base_ptr;
      end else if (load) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (load) begin
        out_vld <= 1'b1;
      end else if (m_ready_i) begin
        out_vld <= 1'b0;
      end
      // Hold after a packet until the host answers
      if (strobe_i.next || strobe_i.redo) begin
        wait_q <= 1'b0;
      end else if (out_vld && m_ready_i && out_q.last) begin
        wait_q <= 1'b1;
      end
    end
  end

  assign m_o       = out_q;
  assign m_valid_o = out_vld;

  // Staged byte never lands on a slot still held for replay
  a_no_overwrite: assert property (@(posedge clock) disable iff (!rst_n_i || clear_i)
    stage_vld |-> (stage_ptr - base_ptr) <
                  usb_ep_pkg::PTR_BITS'(usb_ep_pkg::FIFO_DEPTH));

  // Host times out only a packet it has fully received
  a_redo_sent: assert property (@(posedge clock) disable iff (!rst_n_i || clear_i)
    strobe_i.redo |-> wait_q);

endmodule

`default_nettype wire

// File: hw/residual_counter.sv
`timescale 1ns/1ps
`default_nettype none

module residual_counter (
  input  wire logic                      clock,
  input  wire logic                      rst_n_i,
  input  wire logic                      clear_i,
  input  wire usb_ep_pkg::ep_state_e     state_i,
  input  wire logic                      cmd_vld_i,
  input  wire usb_ep_pkg::ep_cmd_t       cmd_i,
  input  wire logic                      beat_i,
  input  wire logic [7:0]                beat_data_i,
  output logic [15:0]                    residual_o
);

  logic        apb_q;
  logic [1:0]  shifted_q;
  logic [15:0] residual_q;

  always_ff @(posedge clock) begin
    if (!rst_n_i || clear_i) begin
      apb_q      <= 1'b0;
      shifted_q  <= '0;
      residual_q <= '0;
    end else if (state_i == usb_ep_pkg::IDLE && cmd_vld_i) begin
      // Full 64 KiB request wraps to zero
      apb_q      <= cmd_i.apb;
      shifted_q  <= '0;
      residual_q <= cmd_i.len + 16'd1;
    end else if (state_i == usb_ep_pkg::SEND && beat_i) begin
      if (!apb_q) begin
        // AXI, bytes still owed to the host
        residual_q <= residual_q - 16'd1;
      end else if (!shifted_q[1]) begin
        // APB value, low byte arrives first
        residual_q <= {beat_data_i, residual_q[15:8]};
        shifted_q  <= shifted_q + 2'd1;
      end
    end
  end

  assign residual_o = residual_q;

endmodule

`default_nettype wire

// File: hw/status_builder.sv
`timescale 1ns/1ps
`default_nettype none

module status_builder (
  input  wire logic                      clock,
  input  wire logic                      rst_n_i,
  input  wire logic                      clear_i,
  input  wire usb_ep_pkg::ep_state_e     state_i,
  input  wire logic [3:0]                tag_i,
  input  wire logic [15:0]               residual_i,
  // Data from the bus side
  input  wire usb_ep_pkg::axis_byte_t    dat_i,
  input  wire logic                      dat_valid_i,
  output logic                           dat_ready_o,
  // Into the packet FIFO
  output usb_ep_pkg::axis_byte_t         fifo_o,
  output logic                           fifo_valid_o,
  input  wire logic                      fifo_ready_i,
  output logic                           resp_done_o
);

  logic [55:0] word_q;
  logic [2:0]  left_q;
  logic [3:0]  tag_q;
  logic        in_send;
  logic        sending;
  logic        load;

  assign in_send = state_i == usb_ep_pkg::SEND;
  assign sending = state_i == usb_ep_pkg::RESP && left_q != 3'd0;

  // First RESP cycle, nothing left over from a previous block
  assign load = state_i == usb_ep_pkg::RESP && left_q == 3'd0;

  // Data passes straight through during SEND
  assign dat_ready_o  = in_send && fifo_ready_i;
  assign fifo_valid_o = in_send ? dat_valid_i : sending;
  assign fifo_o       = in_send ? dat_i : {word_q[7:0], left_q == 3'd1};

  // Status byte is the only one flagged last
  assign resp_done_o = sending && fifo_ready_i && left_q == 3'd1;

  always_ff @(posedge clock) begin
    // Tag tracks the command bus until the transfer leaves IDLE
    if (state_i == usb_ep_pkg::IDLE) begin
      tag_q <= tag_i;
    end
    // Magic goes out T, A, R, T so its bytes are stored reversed
    if (load) begin
      word_q <= {tag_q, usb_ep_pkg::STATUS_SUCCESS, residual_i,
                 usb_ep_pkg::MAGIC[7:0], usb_ep_pkg::MAGIC[15:8],
                 usb_ep_pkg::MAGIC[23:16], usb_ep_pkg::MAGIC[31:24]};
    end else if (sending && fifo_ready_i) begin
      word_q <= {8'h00, word_q[55:8]};
    end
  end

  // Bytes of the status block still to push
  always_ff @(posedge clock) begin
    if (!rst_n_i || clear_i) begin
      left_q <= '0;
    end else if (load) begin
      left_q <= 3'(usb_ep_pkg::STATUS_BYTES);
    end else if (sending && fifo_ready_i) begin
      left_q <= left_q - 3'd1;
    end
  end

endmodule

`default_nettype wire

// File: hw/bulk_in_ep.sv
`timescale 1ns/1ps
`default_nettype none

module bulk_in_ep (
  input  wire logic                                 clock,
  input  wire logic                                 rst_n_i,
  // Control pipe
  input  wire logic                                 set_conf_i,
  input  wire logic                                 clr_conf_i,
  input  wire logic [usb_ep_pkg::SIZE_BITS-1:0]     max_size_i,
  // USB controller
  input  wire logic                                 selected_i,
  input  wire logic                                 ack_recv_i,
  input  wire logic                                 ack_sent_i,
  input  wire logic                                 timedout_i,
  output logic                                      ep_ready_o,
  output logic                                      stalled_o,
  output logic                                      parity_o,
  // Decoded command
  input  wire logic                                 cmd_vld_i,
  input  wire usb_ep_pkg::ep_cmd_t                  cmd_i,
  // Read data from AXI or APB
  input  wire usb_ep_pkg::axis_byte_t               dat_i,
  input  wire logic                                 dat_valid_i,
  output logic                                      dat_ready_o,
  // Bulk-In stream to the host
  output usb_ep_pkg::axis_byte_t                    usb_o,
  output logic                                      usb_valid_o,
  input  wire logic                                 usb_ready_i
);

  wire usb_ep_pkg::ep_state_e           state;
  wire usb_ep_pkg::pkt_strobe_t         strobe;
  wire usb_ep_pkg::axis_byte_t          fifo_in;
  wire logic                            clear;
  wire logic                            fifo_in_valid;
  wire logic                            fifo_in_ready;
  wire logic                            resp_done;
  wire logic                            data_beat;
  wire logic                            data_done;
  wire logic [usb_ep_pkg::PTR_BITS-1:0] fifo_space;
  wire logic [15:0]                     residual;

  // Data handshake, and its last beat
  assign data_beat = dat_valid_i && dat_ready_o;
  assign data_done = data_beat && dat_i.last;

  bulk_in_ctrl bulk_in_ctrl_inst (
    .clock        (clock),
    .rst_n_i      (rst_n_i),
    .set_conf_i   (set_conf_i),
    .clr_conf_i   (clr_conf_i),
    .max_size_i   (max_size_i),
    .selected_i   (selected_i),
    .ack_recv_i   (ack_recv_i),
    .ack_sent_i   (ack_sent_i),
    .timedout_i   (timedout_i),
    .cmd_vld_i    (cmd_vld_i),
    .data_beat_i  (data_beat),
    .data_done_i  (data_done),
    .resp_done_i  (resp_done),
    .fifo_space_i (fifo_space),
    .state_o      (state),
    .strobe_o     (strobe),
    .clear_o      (clear),
    .ep_ready_o   (ep_ready_o),
    .stalled_o    (stalled_o),
    .parity_o     (parity_o)
  );

  residual_counter residual_counter_inst (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .clear_i     (clear),
    .state_i     (state),
    .cmd_vld_i   (cmd_vld_i),
    .cmd_i       (cmd_i),
    .beat_i      (data_beat),
    .beat_data_i (dat_i.data),
    .residual_o  (residual)
  );

  status_builder status_builder_inst (
    .clock        (clock),
    .rst_n_i      (rst_n_i),
    .clear_i      (clear),
    .state_i      (state),
    .tag_i        (cmd_i.tag),
    .residual_i   (residual),
    .dat_i        (dat_i),
    .dat_valid_i  (dat_valid_i),
    .dat_ready_o  (dat_ready_o),
    .fifo_o       (fifo_in),
    .fifo_valid_o (fifo_in_valid),
    .fifo_ready_i (fifo_in_ready),
    .resp_done_o  (resp_done)
  );

  packet_fifo packet_fifo_inst (
    .clock     (clock),
    .rst_n_i   (rst_n_i),
    .clear_i   (clear),
    .strobe_i  (strobe),
    .s_i       (fifo_in),
    .s_valid_i (fifo_in_valid),
    .s_ready_o (fifo_in_ready),
    .m_o       (usb_o),
    .m_valid_o (usb_valid_o),
    .m_ready_i (usb_ready_i),
    .space_o   (fifo_space)
  );

endmodule

`default_nettype wire

// File: verification/bulk_in_checker.sv
`timescale 1ns/1ps
`default_nettype none

module bulk_in_checker (
  input  wire logic                    clock,
  input  wire logic                    rst_n_i,
  // Watched DUT ports
  input  wire usb_ep_pkg::axis_byte_t  usb_i,
  input  wire logic                    usb_valid_i,
  input  wire logic                    usb_ready_i,
  input  wire logic                    dat_ready_i,
  input  wire logic                    ep_ready_i,
  input  wire logic                    stalled_i,
  input  wire logic                    parity_i,
  // Expected stream and flag requests from the testbench
  input  wire logic                    exp_push_i,
  input  wire usb_ep_pkg::axis_byte_t  exp_i,
  input  wire logic                    flag_chk_i,
  input  wire logic [4:0]              flag_exp_i,
  output logic [31:0]                  pending_o,
  output logic [31:0]                  errors_o,
  output logic [31:0]                  beats_o
);

  usb_ep_pkg::axis_byte_t exp_q[$];

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
      errors_o = errors_o + 1;
    end
  endtask

  initial begin
    pending_o = 0;
    errors_o  = 0;
    beats_o   = 0;
  end

  always @(posedge clock) begin
    usb_ep_pkg::axis_byte_t exp;
    if (exp_push_i) begin
      exp_q.push_back(exp_i);
    end
    // Control outputs are checked during reset too
    if (flag_chk_i) begin
      compare_bit("dat_ready_o", flag_exp_i[4], dat_ready_i);
      compare_bit("usb_valid_o", flag_exp_i[3], usb_valid_i);
      compare_bit("ep_ready_o", flag_exp_i[2], ep_ready_i);
      compare_bit("stalled_o", flag_exp_i[1], stalled_i);
      compare_bit("parity_o", flag_exp_i[0], parity_i);
    end
    if (rst_n_i && usb_valid_i && usb_ready_i) begin
      beats_o = beats_o + 1;
      if (exp_q.size() == 0) begin
        $display("Byte %h arrived on usb_o when no byte was expected", usb_i.data);
        errors_o = errors_o + 1;
      end else begin
        exp = exp_q.pop_front();
        if (exp.data !== usb_i.data) begin
          $display("ERR %0t usb_o.data expected %h actual %h", $time, exp.data, usb_i.data);
          errors_o = errors_o + 1;
        end
        if (exp.last !== usb_i.last) begin
          $display("ERR %0t usb_o.last expected %b actual %b", $time, exp.last, usb_i.last);
          errors_o = errors_o + 1;
        end
      end
    end
    pending_o = exp_q.size();
  end

endmodule

`default_nettype wire

// File: verification/bulk_in_ep_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bulk_in_ep_tb;

  // One test row with to_pkt of 8'hff for no host timeout
  typedef struct packed {
    logic        apb;
    logic [3:0]  tag;
    logic [15:0] len;
    logic [15:0] bytes;
    logic [9:0]  max_size;
    logic [7:0]  to_pkt;
    logic        stall;
  } row_t;

  localparam int ROWS = 6;

  logic clock;
  logic rst_n_i;
  logic set_conf_i;
  logic clr_conf_i;
  logic [9:0] max_size_i;
  logic selected_i;
  logic ack_recv_i;
  logic ack_sent_i;
  logic timedout_i;
  logic ep_ready_o;
  logic stalled_o;
  logic parity_o;
  logic cmd_vld_i;
  usb_ep_pkg::ep_cmd_t cmd_i;
  usb_ep_pkg::axis_byte_t dat_i;
  logic dat_valid_i;
  logic dat_ready_o;
  usb_ep_pkg::axis_byte_t usb_o;
  logic usb_valid_o;
  logic usb_ready_i;

  logic exp_push;
  usb_ep_pkg::axis_byte_t exp_byte;
  logic flag_chk;
  logic [4:0] flag_exp;
  logic [31:0] pending;
  logic [31:0] errors;
  logic [31:0] beats;

  row_t rows [ROWS];
  logic [7:0] data_buf [1024];
  logic [7:0] status [7];
  logic gap_pat [256];
  integer seed;
  int cycles;
  int limit;
  int cur_row;
  int cur_to;
  int host_row;
  int pkt_seen;
  int gap_idx;
  logic ack_due;
  logic to_due;
  logic exp_par;

  bulk_in_ep bulk_in_ep_inst (.*);

  bulk_in_checker bulk_in_checker_inst (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .usb_i       (usb_o),
    .usb_valid_i (usb_valid_o),
    .usb_ready_i (usb_ready_i),
    .dat_ready_i (dat_ready_o),
    .ep_ready_i  (ep_ready_o),
    .stalled_i   (stalled_o),
    .parity_i    (parity_o),
    .exp_push_i  (exp_push),
    .exp_i       (exp_byte),
    .flag_chk_i  (flag_chk),
    .flag_exp_i  (flag_exp),
    .pending_o   (pending),
    .errors_o    (errors),
    .beats_o     (beats)
  );

  always #2 clock = ~clock;

  // Run limit from the row lengths
  always @(posedge clock) begin
    cycles = cycles + 1;
    if (limit != 0 && cycles > limit) begin
      $display("Run stopped after %0d cycles without finishing", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // Host model with ready gaps and an ack or timeout after each packet's last byte
  always @(negedge clock) begin
    if (host_row != cur_row) begin
      host_row = cur_row;
      pkt_seen = 0;
    end
    ack_recv_i = 1'b0;
    timedout_i = 1'b0;
    if (ack_due) begin
      timedout_i = to_due;
      ack_recv_i = !to_due;
      ack_due = 1'b0;
    end
    usb_ready_i = gap_pat[gap_idx % 256];
    gap_idx = gap_idx + 1;
    // Beat transfers at the coming rising edge
    if (usb_valid_o && usb_ready_i && usb_o.last) begin
      ack_due = 1'b1;
      to_due = pkt_seen == cur_to;
      pkt_seen = pkt_seen + 1;
    end
  end

  task automatic check_flags(input logic [4:0] exp);
    @(negedge clock);
    flag_chk = 1'b1;
    flag_exp = exp;
    @(negedge clock);
    flag_chk = 1'b0;
  endtask

  task automatic push_exp(input logic [7:0] data, input logic last);
    @(negedge clock);
    exp_push = 1'b1;
    exp_byte = {data, last};
  endtask

  // Expected byte k of the whole stream with data before status
  function automatic logic [8:0] exp_item(input row_t r, input int k);
    int s;
    if (k < r.bytes) begin
      return {data_buf[k], ((k + 1) % r.max_size == 0) || (!r.stall && k == r.bytes - 1)};
    end
    s = k - r.bytes;
    return {status[s], s == 6};
  endfunction

  task automatic build_expected(input row_t r);
    int pos;
    int total;
    int cnt;
    int p;
    int rep;
    logic [8:0] item;
    pos = 0;
    p = 0;
    // Stalled transfer only sends its complete packets
    total = r.stall ? (r.bytes / r.max_size) * r.max_size : r.bytes + 7;
    while (pos < total) begin
      cnt = pos < r.bytes ? ((r.bytes - pos < r.max_size) ? r.bytes - pos : r.max_size) : 7;
      for (rep = 0; rep < ((p == r.to_pkt) ? 2 : 1); rep++) begin
        for (int k = pos; k < pos + cnt; k++) begin
          item = exp_item(r, k);
          push_exp(item[8:1], item[0]);
        end
      end
      pos = pos + cnt;
      p = p + 1;
    end
    @(negedge clock);
    exp_push = 1'b0;
  endtask

  task automatic pulse_set_conf();
    @(negedge clock);
    set_conf_i = 1'b1;
    @(negedge clock);
    set_conf_i = 1'b0;
    repeat (3) @(negedge clock);
    exp_par = 1'b0;
  endtask

  task automatic run_row(input int n);
    row_t r;
    int i;
    int err0;
    r = rows[n];
    err0 = errors;
    cur_row = n;
    cur_to = r.to_pkt == 8'hff ? -1 : int'(r.to_pkt);
    for (i = 0; i < r.bytes; i++) begin
      data_buf[i] = $random(seed);
    end
    status[0] = "T";
    status[1] = "A";
    status[2] = "R";
    status[3] = "T";
    if (r.apb) begin
      status[4] = data_buf[0];
      status[5] = data_buf[1];
    end else begin
      status[4] = 8'((r.len + 17'd1 - r.bytes) & 16'hff);
      status[5] = 8'((r.len + 17'd1 - r.bytes) >> 8);
    end
    status[6] = {r.tag, 4'h0};
    max_size_i = r.max_size;
    build_expected(r);
    // Command pulse
    @(negedge clock);
    cmd_i = {r.apb, r.tag, r.len};
    cmd_vld_i = 1'b1;
    @(negedge clock);
    cmd_vld_i = 1'b0;
    i = 0;
    while (i < r.bytes) begin
      dat_i = {data_buf[i], !r.stall && i == r.bytes - 1};
      dat_valid_i = 1'b1;
      if (dat_ready_o) begin
        i = i + 1;
      end
      @(negedge clock);
    end
    dat_valid_i = 1'b0;
    if (r.stall) begin
      // Stall lands exactly TIMEOUT_TICKS idle cycles after the last beat
      repeat (usb_ep_pkg::TIMEOUT_TICKS - 2) @(negedge clock);
      check_flags({1'b1, 1'b0, 1'b1, 1'b0, exp_par});
      check_flags({1'b0, 1'b0, 1'b0, 1'b1, exp_par});
      pulse_set_conf();
      check_flags(5'b00100);
    end else begin
      while (pending != 0) begin
        @(negedge clock);
      end
      repeat (4) @(negedge clock);
    end
    $display("Row %0d apb %0d tag %h bytes %0d max %0d finished with %0d errors",
             n, r.apb, r.tag, r.bytes, r.max_size, errors - err0);
  endtask

  initial begin
    clock = 1'b0;
    rst_n_i = 1'b0;
    set_conf_i = 1'b0;
    clr_conf_i = 1'b0;
    max_size_i = 10'd64;
    selected_i = 1'b1;
    ack_recv_i = 1'b0;
    ack_sent_i = 1'b0;
    timedout_i = 1'b0;
    cmd_vld_i = 1'b0;
    cmd_i = '0;
    dat_i = '0;
    dat_valid_i = 1'b0;
    usb_ready_i = 1'b0;
    exp_push = 1'b0;
    exp_byte = '0;
    flag_chk = 1'b0;
    flag_exp = '0;
    cycles = 0;
    cur_row = -1;
    cur_to = -1;
    host_row = -1;
    pkt_seen = 0;
    gap_idx = 0;
    ack_due = 1'b0;
    to_due = 1'b0;
    exp_par = 1'b0;
    seed = 32'h160f;
    // apb, tag, len, bytes, max_size, timeout packet, stall
    rows[0] = {1'b0, 4'h3, 16'd99, 16'd100, 10'd64, 8'hff, 1'b0};
    rows[1] = {1'b0, 4'h5, 16'd299, 16'd200, 10'd128, 8'd1, 1'b0};
    rows[2] = {1'b1, 4'h9, 16'd3, 16'd4, 10'd8, 8'hff, 1'b0};
    rows[3] = {1'b0, 4'h2, 16'd511, 16'd40, 10'd64, 8'hff, 1'b1};
    rows[4] = {1'b0, 4'hc, 16'd1023, 16'd1024, 10'd512, 8'd0, 1'b0};
    rows[5] = {1'b1, 4'hf, 16'd1, 16'd2, 10'd16, 8'd1, 1'b0};
    for (int g = 0; g < 256; g++) begin
      gap_pat[g] = ($random(seed) & 3) != 0;
    end
    // Setup allowance plus the per-row budget
    limit = 100;
    for (int n = 0; n < ROWS; n++) begin
      limit = limit + (rows[n].bytes + 7) * 4 + 200;
    end
    repeat (5) @(negedge clock);
    check_flags(5'b00000);
    @(negedge clock);
    rst_n_i = 1'b1;
    pulse_set_conf();
    check_flags(5'b00100);
    // Parity toggles only while selected
    repeat (3) begin
      @(negedge clock);
      ack_sent_i = 1'b1;
      exp_par = ~exp_par;
      @(negedge clock);
      ack_sent_i = 1'b0;
    end
    check_flags({4'b0010, exp_par});
    @(negedge clock);
    selected_i = 1'b0;
    ack_sent_i = 1'b1;
    @(negedge clock);
    ack_sent_i = 1'b0;
    selected_i = 1'b1;
    check_flags({4'b0010, exp_par});
    $display("Reset, enable and parity finished with %0d errors", errors);
    for (int n = 0; n < ROWS; n++) begin
      run_row(n);
    end
    $display("Rows %0d, bytes seen %0d, errors %0d", ROWS, beats, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
hw/usb_ep_pkg.sv
hw/bulk_in_ctrl.sv
hw/packet_fifo.sv
hw/residual_counter.sv
hw/status_builder.sv
hw/bulk_in_ep.sv
verification/bulk_in_checker.sv
verification/bulk_in_ep_tb.sv

// File: Makefile
# Verilator build and run of the Bulk-In endpoint testbench

VERILATOR ?= verilator
TOP       ?= bulk_in_ep_tb
FLIST     ?= filelist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat $(FLIST))
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
	  echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
